/* Bender.yml */
package:
  name: icache

sources:
  - files:
      - rtl/icache_pkg.sv
      - rtl/icache_ctrl_fsm.sv
      - rtl/icache_beat_cnt.sv
      - rtl/icache_way_mem.sv
      - rtl/icache_line_buffer.sv
      - rtl/icache_top.sv
  - target: test
    files:
      - dv/tb_bus_mem.sv
      - dv/tb_icache.sv

/* dv/tb_bus_mem.sv */
// ----------------------------------------------------------
// Behavioral bus memory
// Answers cache strobes with 4-beat bursts of address-derived
// data, random gaps and an error region above bit 12
// ----------------------------------------------------------

`timescale 1ns/10ps

module tb_bus_mem import icache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  stb_i,
  input  adr_t  adr_i,
  output logic  stb_ack_o,
  output word_t q_o,
  output logic  ack_o,
  output logic  err_o
);

  localparam int unsigned SEED = 28070;

  adr_t        line_adr;   // Line of the running burst
  int unsigned rnd_init;

  function automatic word_t mem_word(adr_t adr);
    return adr ^ 32'hA5A5_0000;
  endfunction

  // Outputs change 2 ns after the rising edge
  task automatic idle_cycles(int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  initial begin
    stb_ack_o = 1'b0;
    ack_o     = 1'b0;
    err_o     = 1'b0;
    q_o       = '0;
    rnd_init  = $urandom(SEED);  // Only seeding point of the run
    forever begin
      idle_cycles(1);
      if (rst_ni && stb_i) begin
        line_adr = adr_i;
        idle_cycles($urandom_range(3));
        stb_ack_o = 1'b1;
        idle_cycles(1);
        stb_ack_o = 1'b0;
        for (int b = 0; b < BURST_LEN; b++) begin
          idle_cycles($urandom_range(3));  // Gap before each beat
          q_o   = mem_word(line_adr + adr_t'(4 * b));
          err_o = line_adr[12] && (b == 1);  // Second beat of the error region
          ack_o = 1'b1;
          idle_cycles(1);
          ack_o = 1'b0;
          err_o = 1'b0;
        end
      end
    end
  end

endmodule

/* dv/tb_icache.sv */
// ----------------------------------------------------------
// Instruction cache testbench
// Table-driven fetches against a behavioral bus memory, with
// back-to-back hits and a two-way residency check
// ----------------------------------------------------------

`timescale 1ns/10ps

module tb_icache import icache_pkg::*; ();

  localparam int unsigned TIMEOUT = 200;  // Cycles per wait

  logic  clk = 1'b0;
  logic  rst_n;
  logic  mem_req, mem_stall, invalidate;
  adr_t  mem_adr, biu_adri;
  word_t parcel, biu_q;
  logic  parcel_valid, parcel_error;
  logic  biu_stb, biu_stb_ack, biu_ack, biu_err;

  int unsigned stb_cnt  = 0;   // Rising strobes seen so far
  logic        stb_seen = 1'b0;
  adr_t        stb_adr  = '0;  // Line address of the latest strobe

  // Stimulus table columns
  string tst_name [$];
  adr_t  tst_adr  [$];
  logic  tst_inv  [$];
  word_t tst_word [$];
  logic  tst_err  [$];
  logic  tst_stb  [$];

  always #10 clk = ~clk;

  icache_top i_dut (
    .clk_i (clk), .rst_ni (rst_n),
    .mem_req_i (mem_req), .mem_adr_i (mem_adr), .mem_stall_o (mem_stall),
    .parcel_o (parcel), .parcel_valid_o (parcel_valid), .parcel_error_o (parcel_error),
    .invalidate_i (invalidate),
    .biu_stb_o (biu_stb), .biu_stb_ack_i (biu_stb_ack), .biu_adri_o (biu_adri),
    .biu_q_i (biu_q), .biu_ack_i (biu_ack), .biu_err_i (biu_err)
  );

  tb_bus_mem i_bus_mem (
    .clk_i (clk), .rst_ni (rst_n), .stb_i (biu_stb), .adr_i (biu_adri),
    .stb_ack_o (biu_stb_ack), .q_o (biu_q), .ack_o (biu_ack), .err_o (biu_err)
  );

  // Bus observation mid-cycle
  always @(negedge clk) begin
    if (rst_n && biu_stb && !stb_seen) begin
      stb_cnt = stb_cnt + 1;
      stb_adr = biu_adri;
    end
    stb_seen = biu_stb;
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) report_failure($sformatf("ERROR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) report_failure($sformatf("ERROR %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_adr(string name, adr_t exp, adr_t act);
    if (act !== exp) report_failure($sformatf("ERROR %s expected %h actual %h", name, exp, act));
  endtask

  // Bus memory rule for the word at an address
  function automatic word_t bus_word(adr_t adr);
    return {adr[PLEN-1:2], 2'b00} ^ 32'hA5A5_0000;
  endfunction

  task automatic add_test(string name, adr_t adr, logic inv, word_t word, logic err,
                          logic stb);
    tst_name.push_back(name);
    tst_adr.push_back(adr);
    tst_inv.push_back(inv);
    tst_word.push_back(word);
    tst_err.push_back(err);
    tst_stb.push_back(stb);
  endtask

  // ----------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------
  task automatic wait_parcel(string name);
    int unsigned cycles;
    cycles = 0;
    while (!parcel_valid) begin
      if (cycles == TIMEOUT) begin
        report_failure($sformatf("%s never delivered a parcel in %0d cycles", name, TIMEOUT));
      end
      @(posedge clk);
      #2;
      cycles++;
    end
  endtask

  task automatic fetch_word(string name, adr_t adr, word_t exp_word, logic exp_err);
    mem_req = 1'b1;
    mem_adr = adr;
    @(posedge clk);
    #2;
    mem_req = 1'b0;
    wait_parcel(name);
    if (!exp_err) check_word(name, exp_word, parcel);
    check_flag({name, " error"}, exp_err, parcel_error);
  endtask

  task automatic fetch(string name, adr_t adr, word_t exp_word, logic exp_err, logic exp_stb);
    int unsigned start;
    start = stb_cnt;
    fetch_word(name, adr, exp_word, exp_err);
    check_flag({name, " strobe"}, exp_stb, stb_cnt != start);
    if (stb_cnt - start > 1) report_failure({name, " caused more than one bus strobe"});
    if (exp_stb) check_adr({name, " line"}, adr & ~adr_t'(BLOCK_BYTES - 1), stb_adr);
  endtask

  task automatic invalidate_all(string name);
    int unsigned cycles;
    cycles = 0;
    // The pulse only counts in idle with no fetch pending
    while (mem_stall || parcel_valid) begin
      if (cycles == TIMEOUT) report_failure("Cache never went idle before the invalidation");
      @(posedge clk);
      #2;
      cycles++;
    end
    cycles     = 0;
    invalidate = 1'b1;
    @(posedge clk);
    #2;
    invalidate = 1'b0;
    check_flag({name, " inval stall"}, 1'b1, mem_stall);
    while (mem_stall) begin
      if (cycles == TIMEOUT) report_failure("Invalidation never ended, stall stayed high");
      @(posedge clk);
      #2;
      cycles++;
    end
    check_flag({name, " inval length"}, 1'b1, cycles == SETS);  // One cycle per set
  endtask

  // One new fetch per cycle over a resident line
  task automatic hit_burst(string name, adr_t base);
    int unsigned start;
    start   = stb_cnt;
    mem_req = 1'b1;
    mem_adr = base;
    for (int i = 0; i < BURST_LEN; i++) begin
      @(posedge clk);
      #2;
      check_flag({name, " valid"}, 1'b1, parcel_valid);
      check_flag({name, " stall"}, 1'b0, mem_stall);
      check_word(name, bus_word(base + adr_t'(4 * i)), parcel);
      if (i < BURST_LEN - 1) mem_adr = base + adr_t'(4 * (i + 1));
      else mem_req = 1'b0;
    end
    check_flag({name, " strobe"}, 1'b0, stb_cnt != start);
  endtask

  // Random replacement may pick one way twice, so refetch until a round hits both
  task automatic settle_pair(adr_t adr_a, adr_t adr_b);
    int unsigned start;
    for (int round = 0; round < 16; round++) begin
      start = stb_cnt;
      fetch_word("pair_a", adr_a, bus_word(adr_a), 1'b0);
      fetch_word("pair_b", adr_b, bus_word(adr_b), 1'b0);
      if (stb_cnt == start) return;
    end
    report_failure("Two lines of one set never stayed resident together");
  endtask

  initial begin
    rst_n      = 1'b0;
    mem_req    = 1'b0;
    mem_adr    = '0;
    invalidate = 1'b0;
    //        name               address       inv   word          err   stb
    add_test("cold_fetch",      32'h0000_0104, 1'b0, 32'hA5A5_0104, 1'b0, 1'b1);
    add_test("repeat_hit",      32'h0000_010C, 1'b0, 32'hA5A5_010C, 1'b0, 1'b0);
    add_test("other_set",       32'h0000_0238, 1'b0, 32'hA5A5_0238, 1'b0, 1'b1);
    add_test("err_fetch",       32'h0000_1054, 1'b0, 32'h0000_0000, 1'b1, 1'b1);
    add_test("err_refetch",     32'h0000_1058, 1'b0, 32'h0000_0000, 1'b1, 1'b1);
    add_test("inval_refetch",   32'h0000_0108, 1'b1, 32'hA5A5_0108, 1'b0, 1'b1);
    add_test("after_inval_hit", 32'h0000_0100, 1'b0, 32'hA5A5_0100, 1'b0, 1'b0);
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int t = 0; t < tst_name.size(); t++) begin
      if (tst_inv[t]) invalidate_all(tst_name[t]);
      fetch(tst_name[t], tst_adr[t], tst_word[t], tst_err[t], tst_stb[t]);
    end
    hit_burst("back_to_back", 32'h0000_0100);
    settle_pair(32'h0000_0104, 32'h0000_0304);  // Same set, different tags
    $display("All checks passed");
    $finish;
  end

endmodule

/* rtl/icache_beat_cnt.sv */
// ----------------------------------------------------------
// Beat counter
// Numbers burst beats during a fill and walks the set index
// during invalidation
// ----------------------------------------------------------

`timescale 1ns/10ps

module icache_beat_cnt import icache_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clr_i,
  input  logic inc_i,
  input  logic walk_i,
  output idx_t cnt_o,
  output logic last_o
);

  idx_t cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (inc_i) begin
      cnt_q <= cnt_q + idx_t'(1);
    end
  end

  assign cnt_o  = cnt_q;
  // Last set when walking, otherwise last burst beat
  assign last_o = walk_i ? (cnt_q == idx_t'(SETS - 1))
                         : (cnt_q == idx_t'(BURST_LEN - 1));

endmodule

/* rtl/icache_ctrl_fsm.sv */
// ----------------------------------------------------------
// Instruction cache controller
// Tracks the pending fetch, runs the miss fill over the bus
// and walks all sets on invalidation
// ----------------------------------------------------------

`timescale 1ns/10ps

module icache_ctrl_fsm import icache_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic mem_req_i,
  input  logic invalidate_i,
  input  logic hit_i,
  input  logic last_beat_i,
  input  logic fill_err_i,
  input  logic biu_stb_ack_i,
  input  logic biu_ack_i,
  output logic mem_stall_o,
  output logic accept_o,
  output logic biu_stb_o,
  output logic beat_clr_o,
  output logic beat_inc_o,
  output logic fill_we_o,
  output logic inval_we_o,
  output logic filling_o,
  output logic hit_valid_o,
  output logic fill_valid_o
);

  ctrl_state_t state_q, state_d;
  logic        pending_q;   // Accepted fetch not yet answered
  logic        miss;

  assign miss     = (state_q == ST_IDLE) && pending_q && !hit_i;
  assign accept_o = mem_req_i && !mem_stall_o;

  // ----------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------
  assign mem_stall_o  = miss || (state_q == ST_REQ) || (state_q == ST_FILL) ||
                        (state_q == ST_INVAL);
  assign hit_valid_o  = (state_q == ST_IDLE) && pending_q && hit_i;
  assign fill_valid_o = (state_q == ST_DONE);
  assign biu_stb_o    = (state_q == ST_REQ);
  assign fill_we_o    = (state_q == ST_DONE) && !fill_err_i;  // Errored lines are dropped
  assign inval_we_o   = (state_q == ST_INVAL);
  // Freezes the replacement LFSR while a line is on its way
  assign filling_o    = (state_q == ST_REQ) || (state_q == ST_FILL) || (state_q == ST_DONE);
  assign beat_inc_o   = ((state_q == ST_FILL) && biu_ack_i) || (state_q == ST_INVAL);

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------
  always_comb begin
    state_d    = state_q;
    beat_clr_o = 1'b0;
    unique case (state_q)
      ST_IDLE: begin
        if (miss) begin
          state_d    = ST_REQ;
          beat_clr_o = 1'b1;
        end else if (!pending_q && invalidate_i) begin
          state_d    = ST_INVAL;
          beat_clr_o = 1'b1;
        end
      end
      ST_REQ:   if (biu_stb_ack_i) state_d = ST_FILL;
      ST_FILL:  if (biu_ack_i && last_beat_i) state_d = ST_DONE;
      ST_DONE:  state_d = ST_IDLE;
      ST_INVAL: if (last_beat_i) state_d = ST_IDLE;  // Last set cleared
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      pending_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept_o) pending_q <= 1'b1;  // May overlap a delivery
      else if (hit_valid_o || fill_valid_o) pending_q <= 1'b0;
    end
  end

endmodule

/* rtl/icache_line_buffer.sv */
// ----------------------------------------------------------
// Fill line buffer
// Collects the burst beats of a fill into one line, keeps a
// sticky bus error and picks the requested word
// ----------------------------------------------------------

`timescale 1ns/10ps

module icache_line_buffer import icache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  beat_i,
  input  woff_t beat_cnt_i,
  input  logic  clr_i,
  input  word_t q_i,
  input  logic  err_i,
  input  woff_t woff_i,
  output line_t line_o,
  output logic  err_o,
  output word_t word_o
);

  line_t line_q;
  logic  err_q;

  // Beats arrive in ascending order from the line start
  always_ff @(posedge clk_i) begin
    if (beat_i) line_q[beat_cnt_i*XLEN +: XLEN] <= q_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else if (clr_i) begin
      err_q <= 1'b0;
    end else if (beat_i && err_i) begin
      err_q <= 1'b1;  // Held for the rest of the burst
    end
  end

  assign line_o = line_q;
  assign err_o  = err_q;
  assign word_o = line_q[woff_i*XLEN +: XLEN];

endmodule

/* rtl/icache_pkg.sv */
// ----------------------------------------------------------
// Instruction cache package
// Fixed geometry, vector types and controller states for a
// 2-way set-associative instruction cache
// ----------------------------------------------------------

package icache_pkg;

  // ----------------------------------------------------------
  // Geometry
  // ----------------------------------------------------------
  localparam int XLEN        = 32;
  localparam int PLEN        = 32;
  localparam int BLOCK_BYTES = 16;
  localparam int BURST_LEN   = BLOCK_BYTES / (XLEN / 8);  // 4 beats per line
  localparam int WAYS        = 2;
  localparam int SETS        = 16;
  localparam int OFFS_BITS   = $clog2(BLOCK_BYTES);
  localparam int WORD_BITS   = $clog2(BURST_LEN);
  localparam int IDX_BITS    = $clog2(SETS);
  localparam int TAG_BITS    = PLEN - IDX_BITS - OFFS_BITS;  // 24
  localparam int LFSR_BITS   = 7;

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------
  typedef logic [PLEN-1:0]          adr_t;
  typedef logic [XLEN-1:0]          word_t;
  typedef logic [BLOCK_BYTES*8-1:0] line_t;
  typedef logic [IDX_BITS-1:0]      idx_t;
  typedef logic [TAG_BITS-1:0]      tag_t;
  typedef logic [WORD_BITS-1:0]     woff_t;
  typedef logic [WAYS-1:0]          way_sel_t;  // One-hot

  typedef enum logic [2:0] {
    ST_IDLE,   // Lookup of a pending fetch
    ST_REQ,    // Strobe held until acknowledged
    ST_FILL,   // Collecting burst beats
    ST_DONE,   // Deliver parcel and store the line
    ST_INVAL   // Walk all sets, clear valid bits
  } ctrl_state_t;

endpackage

/* rtl/icache_top.sv */
// ----------------------------------------------------------
// Instruction cache top level
// Registers the fetch address and ties the controller, beat
// counter, way memory and fill line buffer together
// ----------------------------------------------------------

`timescale 1ns/10ps

module icache_top import icache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  // CPU side
  input  logic  mem_req_i,
  input  adr_t  mem_adr_i,
  output logic  mem_stall_o,
  output word_t parcel_o,
  output logic  parcel_valid_o,
  output logic  parcel_error_o,
  input  logic  invalidate_i,
  // Bus side
  output logic  biu_stb_o,
  input  logic  biu_stb_ack_i,
  output adr_t  biu_adri_o,
  input  word_t biu_q_i,
  input  logic  biu_ack_i,
  input  logic  biu_err_i
);

  adr_t  adr_q;     // Fetch address of the pending request
  logic  accept;
  logic  hit;
  logic  hit_valid, fill_valid;
  logic  beat_clr, beat_inc, last_beat;
  logic  fill_we, inval_we, filling;
  idx_t  beat_cnt;
  line_t fill_line;
  logic  fill_err;
  word_t fill_word, hit_word;

  always_ff @(posedge clk_i) begin
    if (accept) adr_q <= mem_adr_i;
  end

  assign biu_adri_o = {adr_q[PLEN-1:OFFS_BITS], {OFFS_BITS{1'b0}}};  // Line aligned

  // ----------------------------------------------------------
  // Parcel output
  // ----------------------------------------------------------
  assign parcel_valid_o = hit_valid | fill_valid;
  assign parcel_error_o = fill_valid & fill_err;
  assign parcel_o       = hit_valid  ? hit_word  :
                          fill_valid ? fill_word : '0;

  icache_ctrl_fsm u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mem_req_i     (mem_req_i),
    .invalidate_i  (invalidate_i),
    .hit_i         (hit),
    .last_beat_i   (last_beat),
    .fill_err_i    (fill_err),
    .biu_stb_ack_i (biu_stb_ack_i),
    .biu_ack_i     (biu_ack_i),
    .mem_stall_o   (mem_stall_o),
    .accept_o      (accept),
    .biu_stb_o     (biu_stb_o),
    .beat_clr_o    (beat_clr),
    .beat_inc_o    (beat_inc),
    .fill_we_o     (fill_we),
    .inval_we_o    (inval_we),
    .filling_o     (filling),
    .hit_valid_o   (hit_valid),
    .fill_valid_o  (fill_valid)
  );

  icache_beat_cnt u_beat_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clr_i  (beat_clr),
    .inc_i  (beat_inc),
    .walk_i (inval_we),   // Count sets during invalidation
    .cnt_o  (beat_cnt),
    .last_o (last_beat)
  );

  icache_way_mem u_way_mem (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_adr_i    (adr_q),
    .filling_i   (filling),
    .fill_we_i   (fill_we),
    .fill_line_i (fill_line),
    .inval_we_i  (inval_we),
    .inval_idx_i (beat_cnt),
    .hit_o       (hit),
    .hit_word_o  (hit_word)
  );

  icache_line_buffer u_line_buf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .beat_i     (beat_inc & filling),  // Burst beats only, not the set walk
    .beat_cnt_i (beat_cnt[WORD_BITS-1:0]),
    .clr_i      (beat_clr),
    .q_i        (biu_q_i),
    .err_i      (biu_err_i),
    .woff_i     (adr_q[2 +: WORD_BITS]),
    .line_o     (fill_line),
    .err_o      (fill_err),
    .word_o     (fill_word)
  );

endmodule

/* rtl/icache_way_mem.sv */
// ----------------------------------------------------------
// Way memory
// Tag, valid and data arrays for both ways with hit compare,
// line write on fill and random replacement
// ----------------------------------------------------------

`timescale 1ns/10ps

module icache_way_mem import icache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  adr_t  rd_adr_i,
  input  logic  filling_i,
  input  logic  fill_we_i,
  input  line_t fill_line_i,
  input  logic  inval_we_i,
  input  idx_t  inval_idx_i,
  output logic  hit_o,
  output word_t hit_word_o
);

  tag_t             tag_mem  [WAYS][SETS];
  line_t            data_mem [WAYS][SETS];
  logic [SETS-1:0]  valid_q  [WAYS];

  logic [LFSR_BITS-1:0] lfsr_q;
  way_sel_t             fill_way, hit_way;
  idx_t                 idx;
  tag_t                 tag;
  woff_t                woff;
  line_t                hit_line;

  // Address fields
  assign idx  = rd_adr_i[OFFS_BITS +: IDX_BITS];
  assign tag  = rd_adr_i[PLEN-1 -: TAG_BITS];
  assign woff = rd_adr_i[2 +: WORD_BITS];

  // ----------------------------------------------------------
  // Random replacement
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '0;
    end else if (!filling_i) begin
      lfsr_q <= {lfsr_q[LFSR_BITS-2:0], lfsr_q[6] ~^ lfsr_q[5]};  // XNOR, so zero is legal
    end
  end

  assign fill_way = way_sel_t'(1) << lfsr_q[0];

  // ----------------------------------------------------------
  // Lookup
  // ----------------------------------------------------------
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit_way[w] = valid_q[w][idx] && (tag_mem[w][idx] == tag);
      if (hit_way[w]) hit_line = data_mem[w][idx];
    end
  end

  assign hit_o      = |hit_way;
  assign hit_word_o = hit_line[woff*XLEN +: XLEN];

  // ----------------------------------------------------------
  // Array writes
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < WAYS; w++) begin
      if (fill_we_i && fill_way[w]) begin
        tag_mem[w][idx]  <= tag;
        data_mem[w][idx] <= fill_line_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < WAYS; w++) valid_q[w] <= '0;
    end else begin
      for (int w = 0; w < WAYS; w++) begin
        if (inval_we_i) valid_q[w][inval_idx_i] <= 1'b0;  // Both ways of the set
        else if (fill_we_i && fill_way[w]) valid_q[w][idx] <= 1'b1;
      end
    end
  end

endmodule

/* vlog.f */
rtl/icache_pkg.sv
rtl/icache_ctrl_fsm.sv
rtl/icache_beat_cnt.sv
rtl/icache_way_mem.sv
rtl/icache_line_buffer.sv
rtl/icache_top.sv
dv/tb_bus_mem.sv
dv/tb_icache.sv
